// File: rtl/la_pkg.sv
/*
 * shared widths of the capture core
 * host register address map and capture FSM state encoding
 */
package la_pkg;

	localparam int DATA_W = 16; // probe word and host word
	localparam int DIV_W = 24; // sample rate divider
	localparam int CNT_W = 16; // depth and trigger position

	// host register map, one word per address
	typedef enum logic [2:0] {
		REG_CTRL = 3'd0, // bit 0 trigger enable
		REG_DIV_LO = 3'd1, // divider bits 15:0
		REG_DIV_HI = 3'd2, // divider bits 23:16
		REG_TRIG_MASK = 3'd3,
		REG_TRIG_VALUE = 3'd4,
		REG_DEPTH = 3'd5, // samples kept per run
		REG_TRIG_POS = 3'd6 // samples kept before the trigger
	} cfg_reg_e;

	// capture controller states
	typedef enum logic [2:0] {
		CAP_IDLE = 3'd0, // waiting for the first sample
		CAP_PRE = 3'd1, // filling the pre-trigger part
		CAP_WAIT = 3'd2, // pre-fill done, wrapping until trigger
		CAP_POST = 3'd3, // writing samples after the trigger
		CAP_DONE = 3'd4 // buffer complete, held for read-out
	} cap_state_e;

endpackage

// File: rtl/cfg_regs.sv
/*
 * host configuration registers
 * divider halves, trigger mask/value, depth and trigger position with limits
 */
`timescale 1ns/100ps

module cfg_regs #(
	parameter int ADDR_W = 8
) (
	input  logic core_clk,
	input  logic core_rst,
	input  logic cfg_wr,
	input  la_pkg::cfg_reg_e cfg_addr,
	input  logic [la_pkg::DATA_W-1:0] cfg_data,
	output logic trig_en,
	output logic [la_pkg::DIV_W-1:0] sample_div,
	output logic [la_pkg::DATA_W-1:0] trig_mask,
	output logic [la_pkg::DATA_W-1:0] trig_value,
	output logic [la_pkg::CNT_W-1:0] depth,
	output logic [la_pkg::CNT_W-1:0] trig_pos
);
	import la_pkg::*;

	localparam logic [CNT_W-1:0] DEPTH_MAX = CNT_W'(2 ** ADDR_W); // whole buffer

	logic [DATA_W-1:0] div_lo;
	logic [DIV_W-DATA_W-1:0] div_hi;
	logic [CNT_W-1:0] depth_lim; // write data forced into 1..DEPTH_MAX
	logic [CNT_W-1:0] pos_lim; // write data forced below current depth

	assign sample_div = {div_hi, div_lo};

	always_comb begin
		depth_lim = CNT_W'(cfg_data);
		if (depth_lim == '0)
			depth_lim = CNT_W'(1);
		else if (depth_lim > DEPTH_MAX)
			depth_lim = DEPTH_MAX;
		pos_lim = CNT_W'(cfg_data);
		if (pos_lim >= depth)
			pos_lim = depth - 1'b1; // trigger word must be inside the kept window
	end

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			trig_en <= 1'b0;
			div_lo <= '0;
			div_hi <= '0;
			trig_mask <= '0; // every sample matches
			trig_value <= '0;
			depth <= DEPTH_MAX;
			trig_pos <= '0;
		end else if (cfg_wr) begin
			unique case (cfg_addr)
				REG_CTRL: trig_en <= cfg_data[0];
				REG_DIV_LO: div_lo <= cfg_data;
				REG_DIV_HI: div_hi <= cfg_data[DIV_W-DATA_W-1:0];
				REG_TRIG_MASK: trig_mask <= cfg_data;
				REG_TRIG_VALUE: trig_value <= cfg_data;
				REG_DEPTH: begin
					depth <= depth_lim;
					// shrinking depth pulls the trigger position along
					if (trig_pos >= depth_lim)
						trig_pos <= depth_lim - 1'b1;
				end
				REG_TRIG_POS: trig_pos <= pos_lim;
				default: ; // unmapped address, write dropped
			endcase
		end
	end

endmodule

// File: rtl/sample_ctrl.sv
/*
 * enable synchronizer and run flag
 * sample rate divider and probe input register
 */
`timescale 1ns/100ps

module sample_ctrl (
	input  logic core_clk,
	input  logic core_rst,
	input  logic sys_en,
	input  logic capture_done,
	input  logic [la_pkg::DIV_W-1:0] sample_div,
	input  logic [la_pkg::DATA_W-1:0] ext_data,
	output logic run_en,
	output logic ledn,
	output logic sample_valid,
	output logic [la_pkg::DATA_W-1:0] sample_data
);
	import la_pkg::*;

	logic sync0;
	logic sync1; // synchronized sys_en
	logic sync1_d; // previous value for edge detect
	logic run_start;
	logic run_stop;
	logic run_nxt;
	logic tick; // sample strobe for the next cycle
	logic [DIV_W-1:0] div_cnt;

	assign run_start = sync1 & ~sync1_d;
	assign run_stop = capture_done | (~sync1 & sync1_d); // done or enable dropped
	assign run_nxt = run_start | (run_en & ~run_stop);

	// first sample on the first run cycle, then every sample_div+1
	assign tick = run_start | (run_en & ~run_stop & (div_cnt >= sample_div));

	assign ledn = ~run_en; // led on while running

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			sync0 <= 1'b0;
			sync1 <= 1'b0;
			sync1_d <= 1'b0;
			run_en <= 1'b0;
			sample_valid <= 1'b0;
			div_cnt <= '0;
		end else begin
			sync0 <= sys_en;
			sync1 <= sync0;
			sync1_d <= sync1;
			run_en <= run_nxt;
			sample_valid <= tick;
			if (!run_nxt || tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge core_clk) begin
		if (tick)
			sample_data <= ext_data; // probe word taken with the strobe
	end

endmodule

// File: rtl/trigger_match.sv
/*
 * single stage mask/value trigger
 * armed at run start, fires once on a ready valid sample
 */
`timescale 1ns/100ps

module trigger_match (
	input  logic core_clk,
	input  logic core_rst,
	input  logic run_en,
	input  logic trig_en,
	input  logic [la_pkg::DATA_W-1:0] trig_mask,
	input  logic [la_pkg::DATA_W-1:0] trig_value,
	input  logic trig_ready,
	input  logic sample_valid,
	input  logic [la_pkg::DATA_W-1:0] sample_data,
	output logic trig_hit
);

	logic run_en_d;
	logic armed;
	logic arm_now; // includes the first run cycle
	logic match;
	logic hit_cond;

	assign arm_now = armed | (run_en & ~run_en_d);

	// trigger off means any sample matches
	assign match = ~trig_en | (((sample_data ^ trig_value) & trig_mask) == '0);

	assign hit_cond = arm_now & trig_ready & sample_valid & match;

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			run_en_d <= 1'b0;
			armed <= 1'b0;
			trig_hit <= 1'b0;
		end else begin
			run_en_d <= run_en;
			armed <= arm_now & ~hit_cond & run_en; // one hit per run
			trig_hit <= hit_cond; // lines up with the delayed write
		end
	end

endmodule

// File: rtl/capture_ctrl.sv
/*
 * capture FSM for pre-trigger and post-trigger samples
 * circular buffer write addressing and read-back start address
 */
`timescale 1ns/100ps

module capture_ctrl #(
	parameter int ADDR_W = 8
) (
	input  logic core_clk,
	input  logic core_rst,
	input  logic run_en,
	input  logic sample_valid,
	input  logic [la_pkg::DATA_W-1:0] sample_data,
	input  logic trig_hit,
	input  logic [la_pkg::CNT_W-1:0] depth,
	input  logic [la_pkg::CNT_W-1:0] trig_pos,
	output logic trig_ready,
	output logic capture_done,
	output logic wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output logic [la_pkg::DATA_W-1:0] wr_data,
	output logic [ADDR_W-1:0] rd_start
);
	import la_pkg::*;

	cap_state_e state;
	logic d_valid; // sample delayed to meet trig_hit
	logic [DATA_W-1:0] d_data;
	logic run_d;
	logic restart;
	logic [ADDR_W-1:0] wr_ptr; // wraps over the whole buffer
	logic [CNT_W-1:0] pre_cnt; // saturates at trig_pos
	logic [CNT_W-1:0] post_cnt;
	logic [CNT_W-1:0] post_len;
	logic post_phase;
	logic post_last;

	assign post_len = depth - trig_pos; // trigger word included
	assign post_phase = trig_hit | (state == CAP_POST);
	assign post_last = (post_cnt + 1'b1 == post_len);

	// pending write counts toward the pre-fill, so the raw sample may trigger
	assign trig_ready = (state == CAP_WAIT) |
		(((state == CAP_IDLE) | (state == CAP_PRE)) &
		(pre_cnt + CNT_W'(d_valid) >= trig_pos));

	assign wr_en = d_valid & run_en & (state != CAP_DONE);
	assign wr_addr = wr_ptr;
	assign wr_data = d_data;

	// done waits for a new run, other states drop back when the run ends
	assign restart = (state == CAP_DONE) ? (run_en & ~run_d) : ~run_en;

	always_ff @(posedge core_clk) begin
		d_data <= sample_data;
	end

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			state <= CAP_IDLE;
			d_valid <= 1'b0;
			run_d <= 1'b0;
			wr_ptr <= '0;
			pre_cnt <= '0;
			post_cnt <= '0;
			capture_done <= 1'b0;
			rd_start <= '0;
		end else begin
			d_valid <= sample_valid;
			run_d <= run_en;
			capture_done <= 1'b0;
			if (restart) begin
				state <= CAP_IDLE;
				wr_ptr <= '0;
				pre_cnt <= '0;
				post_cnt <= '0;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
				if (post_phase) begin
					post_cnt <= post_cnt + 1'b1;
					if (post_last) begin
						state <= CAP_DONE;
						capture_done <= 1'b1;
						// oldest kept word sits depth behind the next write
						rd_start <= wr_ptr + 1'b1 - depth[ADDR_W-1:0];
					end else begin
						state <= CAP_POST;
					end
				end else begin
					if (pre_cnt < trig_pos)
						pre_cnt <= pre_cnt + 1'b1;
					state <= (pre_cnt + 1'b1 >= trig_pos) ? CAP_WAIT : CAP_PRE;
				end
			end
		end
	end

endmodule

// File: rtl/read_buf.sv
/*
 * circular sample memory
 * host read-out with registered read port and word count
 */
`timescale 1ns/100ps

module read_buf #(
	parameter int ADDR_W = 8
) (
	input  logic core_clk,
	input  logic core_rst,
	input  logic wr_en,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [la_pkg::DATA_W-1:0] wr_data,
	input  logic capture_done,
	input  logic [ADDR_W-1:0] rd_start,
	input  logic [la_pkg::CNT_W-1:0] depth,
	input  logic usb_rd,
	output logic usb_rdy,
	output logic usb_rd_valid,
	output logic [la_pkg::DATA_W-1:0] usb_rdata
);
	import la_pkg::*;

	logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
	logic [ADDR_W-1:0] rd_ptr; // wraps like the write side
	logic [CNT_W-1:0] remain; // words left to hand out
	logic rd_take;

	assign rd_take = usb_rd & usb_rdy; // strobes outside a read-out are dropped

	always_ff @(posedge core_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge core_clk) begin
		if (rd_take)
			usb_rdata <= mem[rd_ptr];
	end

	always_ff @(posedge core_clk or posedge core_rst) begin
		if (core_rst) begin
			usb_rdy <= 1'b0;
			usb_rd_valid <= 1'b0;
			rd_ptr <= '0;
			remain <= '0;
		end else begin
			usb_rd_valid <= rd_take; // data one cycle after the strobe
			if (capture_done) begin
				rd_ptr <= rd_start;
				remain <= depth;
				usb_rdy <= 1'b1;
			end else if (rd_take) begin
				rd_ptr <= rd_ptr + 1'b1;
				remain <= remain - 1'b1;
				if (remain == CNT_W'(1))
					usb_rdy <= 1'b0; // last word taken
			end
		end
	end

endmodule

// File: rtl/logic_analyzer.sv
/*
 * capture core top level
 * config, sampling, trigger, capture and read-out
 */
`timescale 1ns/100ps

module logic_analyzer #(
	parameter int ADDR_W = 8
) (
	input  logic core_clk,
	input  logic core_rst,
	input  logic sys_en,
	input  logic [la_pkg::DATA_W-1:0] ext_data,
	input  logic cfg_wr,
	input  la_pkg::cfg_reg_e cfg_addr,
	input  logic [la_pkg::DATA_W-1:0] cfg_data,
	input  logic usb_rd,
	output logic ledn,
	output logic usb_rdy,
	output logic usb_rd_valid,
	output logic [la_pkg::DATA_W-1:0] usb_rdata
);
	import la_pkg::*;

	// configuration
	logic trig_en;
	logic [DIV_W-1:0] sample_div;
	logic [DATA_W-1:0] trig_mask;
	logic [DATA_W-1:0] trig_value;
	logic [CNT_W-1:0] depth;
	logic [CNT_W-1:0] trig_pos;

	// sample stream and capture control
	logic run_en;
	logic sample_valid;
	logic [DATA_W-1:0] sample_data;
	logic trig_ready;
	logic trig_hit;
	logic capture_done;

	// buffer write side
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [ADDR_W-1:0] rd_start;

	cfg_regs #(.ADDR_W(ADDR_W)) u_cfg (
		.core_clk(core_clk), .core_rst(core_rst),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.trig_en(trig_en), .sample_div(sample_div),
		.trig_mask(trig_mask), .trig_value(trig_value),
		.depth(depth), .trig_pos(trig_pos)
	);

	sample_ctrl u_sample (
		.core_clk(core_clk), .core_rst(core_rst),
		.sys_en(sys_en), .capture_done(capture_done),
		.sample_div(sample_div), .ext_data(ext_data),
		.run_en(run_en), .ledn(ledn),
		.sample_valid(sample_valid), .sample_data(sample_data)
	);

	trigger_match u_trig (
		.core_clk(core_clk), .core_rst(core_rst),
		.run_en(run_en), .trig_en(trig_en),
		.trig_mask(trig_mask), .trig_value(trig_value),
		.trig_ready(trig_ready),
		.sample_valid(sample_valid), .sample_data(sample_data),
		.trig_hit(trig_hit)
	);

	capture_ctrl #(.ADDR_W(ADDR_W)) u_capture (
		.core_clk(core_clk), .core_rst(core_rst),
		.run_en(run_en),
		.sample_valid(sample_valid), .sample_data(sample_data),
		.trig_hit(trig_hit), .depth(depth), .trig_pos(trig_pos),
		.trig_ready(trig_ready), .capture_done(capture_done),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_start(rd_start)
	);

	read_buf #(.ADDR_W(ADDR_W)) u_read (
		.core_clk(core_clk), .core_rst(core_rst),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.capture_done(capture_done), .rd_start(rd_start), .depth(depth),
		.usb_rd(usb_rd),
		.usb_rdy(usb_rdy), .usb_rd_valid(usb_rd_valid), .usb_rdata(usb_rdata)
	);

endmodule

// File: testbench/la_chk.sv
/*
 * concurrent checks on the host read port and the post-reset state
 * bound into logic_analyzer by the testbench
 */
`timescale 1ns/100ps

module la_chk (
	input logic core_clk,
	input logic core_rst,
	input logic usb_rd,
	input logic usb_rdy,
	input logic usb_rd_valid,
	input logic ledn
);

	int unsigned fail_cnt = 0; // summed into the closing count

	// accepted strobe, data exactly one cycle later
	rd_valid_follows: assert property (@(posedge core_clk) disable iff (core_rst)
		usb_rd && usb_rdy |=> usb_rd_valid)
	else begin
		$error("usb_rd_valid missing one cycle after an accepted read");
		fail_cnt++;
	end

	// valid only ever answers a read
	rd_valid_needs_read: assert property (@(posedge core_clk) disable iff (core_rst)
		usb_rd_valid |-> $past(usb_rd && usb_rdy))
	else begin
		$error("usb_rd_valid without an accepted read in the cycle before");
		fail_cnt++;
	end

	// first cycle out of reset is idle
	idle_after_reset: assert property (@(posedge core_clk)
		$fell(core_rst) |-> !usb_rdy && !usb_rd_valid && ledn)
	else begin
		$error("outputs not idle in the cycle after reset");
		fail_cnt++;
	end

endmodule

// File: testbench/tb_logic_analyzer.sv
/*
 * testbench for the logic analyzer capture core
 * register setup, capture runs, host readout, watchdog and summary
 */
`timescale 1ns/100ps

module tb_logic_analyzer;
	import la_pkg::*;

	localparam int ADDR_W = 6; // 64 word buffer

	logic core_clk;
	logic core_rst;
	logic sys_en;
	logic [DATA_W-1:0] ext_data = '0; // counts up once per cycle
	logic cfg_wr;
	cfg_reg_e cfg_addr;
	logic [DATA_W-1:0] cfg_data;
	logic usb_rd;
	logic ledn;
	logic usb_rdy;
	logic usb_rd_valid;
	logic [DATA_W-1:0] usb_rdata;

	int err_cnt = 0;
	int test_cnt = 0;
	int fail_tests = 0;
	int wd_cycles;
	logic [31:0] rng = 32'd73941;
	logic [DATA_W-1:0] words [$]; // words of the last readout

	logic_analyzer #(.ADDR_W(ADDR_W)) dut (.*);

	bind logic_analyzer la_chk chk (
		.core_clk(core_clk), .core_rst(core_rst), .usb_rd(usb_rd),
		.usb_rdy(usb_rdy), .usb_rd_valid(usb_rd_valid), .ledn(ledn)
	);

	initial begin
		core_clk = 1'b0;
		forever #4 core_clk = ~core_clk;
	end

	always @(posedge core_clk) begin
		#1 ext_data = ext_data + 1'b1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int total_errors();
		return err_cnt + int'(dut.chk.fail_cnt); // own checks plus bound ones
	endfunction

	task automatic check_cond(input bit cond, input string msg);
		assert (cond) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			err_cnt++;
		end
	endtask

	task automatic write_reg(input cfg_reg_e addr, input logic [DATA_W-1:0] data);
		@(posedge core_clk);
		#1 cfg_wr = 1'b1;
		cfg_addr = addr;
		cfg_data = data;
		@(posedge core_clk);
		#1 cfg_wr = 1'b0;
	endtask

	task automatic configure(input bit trig_on, input logic [23:0] div, input logic [15:0] mask,
			input logic [15:0] value, input int depth, input int pos);
		write_reg(REG_CTRL, {15'd0, trig_on});
		write_reg(REG_DIV_LO, div[15:0]);
		write_reg(REG_DIV_HI, {8'd0, div[23:16]});
		write_reg(REG_TRIG_MASK, mask);
		write_reg(REG_TRIG_VALUE, value);
		write_reg(REG_DEPTH, DATA_W'(depth)); // depth first, pos is limited by it
		write_reg(REG_TRIG_POS, DATA_W'(pos));
	endtask

	// raise the enable, follow ledn until usb_rdy comes up
	task automatic run_capture();
		bit running;
		running = 1'b0;
		@(posedge core_clk);
		#1 sys_en = 1'b1;
		while (!usb_rdy) begin
			@(posedge core_clk);
			#1;
			if (!ledn)
				running = 1'b1;
			else if (running && !usb_rdy)
				check_cond(1'b0, "ledn high again before capture completion");
		end
		check_cond(running, "ledn never went low during the run");
		check_cond(ledn, "ledn still low after capture completion");
		sys_en = 1'b0;
	endtask

	// one strobe per cycle until usb_rdy drops
	task automatic read_out();
		int guard;
		guard = 0;
		words.delete();
		while (usb_rdy && guard < 2 ** ADDR_W + 4) begin
			usb_rd = 1'b1;
			@(posedge core_clk);
			#1 usb_rd = 1'b0;
			check_cond(usb_rd_valid, "usb_rd_valid low one cycle after read strobe");
			words.push_back(usb_rdata);
			guard++;
		end
		check_cond(!usb_rdy, "usb_rdy still high after readout");
	endtask

	task automatic check_words(input int exp_n, input int step);
		int i;
		check_cond(words.size() == exp_n,
			$sformatf("read %0d words, expected %0d", words.size(), exp_n));
		for (i = 1; i < words.size(); i++)
			check_cond(DATA_W'(words[i] - words[i-1]) == DATA_W'(step),
				$sformatf("word %0d = %h after %h, step %0d", i, words[i], words[i-1], step));
	endtask

	// only the word at pos may carry the low byte of value
	task automatic check_trigger(input logic [DATA_W-1:0] value, input int pos);
		int i;
		for (i = 0; i < words.size(); i++)
			check_cond((words[i][7:0] == value[7:0]) == (i == pos),
				$sformatf("word %0d = %h, trigger byte %h at %0d", i, words[i], value[7:0], pos));
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		if (total_errors() == errs_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			fail_tests++;
			$display("test %0d %s: %0d errors", test_cnt, name, total_errors() - errs_before);
		end
	endtask

	task automatic run_watchdog();
		repeat (wd_cycles) @(posedge core_clk);
		$display("timeout: run still going after %0d cycles", wd_cycles);
		$display("Result: FAILED");
		$finish;
	endtask

	initial begin
		int errs;
		int d4;
		int p4;
		logic [DATA_W-1:0] v4;
		logic [DATA_W-1:0] v5;
		logic [DATA_W-1:0] last_word;
		core_rst = 1'b1;
		sys_en = 1'b0;
		cfg_wr = 1'b0;
		cfg_addr = REG_CTRL;
		cfg_data = '0;
		usb_rd = 1'b0;
		rng = xorshift(rng);
		d4 = 8 + int'(rng % 57); // 8..64
		rng = xorshift(rng);
		p4 = int'(rng % 32'(d4));
		rng = xorshift(rng);
		v4 = rng[15:0];
		rng = xorshift(rng);
		v5 = rng[15:0];
		// depth * (div+1) * 4 per run, plus slack
		wd_cycles = 20 * 1 * 4 + 16 * 4 * 4 + d4 * 1 * 4 + 2 * 64 * 1 * 4 + 2000;
		fork
			run_watchdog();
		join_none
		repeat (3) @(posedge core_clk);
		#1 core_rst = 1'b0;

		errs = total_errors();
		@(posedge core_clk);
		#1 check_cond(!usb_rdy && ledn, "not idle after reset");
		usb_rd = 1'b1;
		@(posedge core_clk);
		#1 usb_rd = 1'b0;
		check_cond(!usb_rd_valid, "usb_rd_valid on a read while idle");
		finish_test("reset and idle", errs);

		errs = total_errors();
		configure(1'b0, 24'd0, 16'h0000, 16'h0000, 20, 0);
		run_capture();
		read_out();
		check_words(20, 1);
		finish_test("untriggered capture", errs);

		errs = total_errors();
		configure(1'b0, 24'd3, 16'h0000, 16'h0000, 16, 0);
		run_capture();
		read_out();
		check_words(16, 4);
		finish_test("divider", errs);

		errs = total_errors();
		configure(1'b1, 24'd0, 16'h00FF, v4, d4, p4);
		run_capture();
		read_out();
		check_words(d4, 1);
		check_trigger(v4, p4);
		finish_test("pre-trigger position", errs);

		errs = total_errors();
		configure(1'b1, 24'd0, 16'h00FF, v5, 100, 200); // both above their limits
		run_capture();
		read_out();
		check_words(64, 1);
		check_trigger(v5, 63);
		last_word = (words.size() > 0) ? words[words.size()-1] : '0;
		write_reg(REG_CTRL, 16'h0000);
		run_capture();
		read_out();
		check_words(64, 1);
		check_cond(words.size() > 0 && words[0] > last_word, "second run returned stale data");
		finish_test("limits and wrap", errs);

		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_tests, total_errors());
		if (total_errors() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: compile.f
rtl/la_pkg.sv
rtl/cfg_regs.sv
rtl/sample_ctrl.sv
rtl/trigger_match.sv
rtl/capture_ctrl.sv
rtl/read_buf.sv
rtl/logic_analyzer.sv
testbench/la_chk.sv
testbench/tb_logic_analyzer.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_logic_analyzer
FLIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIMARGS ?= +verilator+error+limit+1000
PASS_MSG ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
